// File: source/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Cache geometry.
`define ICACHE_WAYS        4
`define ICACHE_SETS        16
`define ICACHE_LINE_WORDS  16

// Word address split as tag | index | offset.
`define ICACHE_ADDR_W      32
`define ICACHE_OFS_W       4
`define ICACHE_IDX_W       4
`define ICACHE_TAG_W       (`ICACHE_ADDR_W - `ICACHE_IDX_W - `ICACHE_OFS_W)

`define ICACHE_WORD_W      32  // Instruction word.
`define ICACHE_LEN_W       8   // Burst length minus one.
`define ICACHE_OP_W        3   // Cache operation code.

`endif

// File: source/icache_core_pkg.sv
`include "icache_defs.svh"

package icache_core_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0] addr_t;      // Word address.
    typedef logic [`ICACHE_WORD_W-1:0] word_t;
    typedef logic [`ICACHE_TAG_W-1:0]  tag_t;
    typedef logic [`ICACHE_IDX_W-1:0]  index_t;
    typedef logic [`ICACHE_OFS_W-1:0]  offset_t;
    typedef logic [`ICACHE_WAYS-1:0]   way_mask_t;  // One bit per way.

    // Only instruction-cache codes are listed.
    typedef enum logic [`ICACHE_OP_W-1:0] {
        op_store_tag = 3'd0,
        op_index_inv = 3'd1,
        op_hit_inv   = 3'd2
    } cacheop_t;

    typedef struct packed {
        addr_t    addr;
        logic     uncache;
        logic     exception;  // Translation fault from the fetch stage.
        logic     cacop_en;
        cacheop_t op;
    } fetch_req_t;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_replace,
        st_refill
    } fsm_state_t;

endpackage

// File: source/icache_mem_pkg.sv
`include "icache_defs.svh"

package icache_mem_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0] mem_addr_t;
    typedef logic [`ICACHE_WORD_W-1:0] mem_data_t;
    typedef logic [`ICACHE_LEN_W-1:0]  mem_len_t;  // Beats minus one.

    typedef struct packed {
        mem_addr_t addr;
        mem_len_t  len;
    } mem_req_t;

    // One beat of read data.
    typedef struct packed {
        mem_data_t data;
        logic      last;
    } mem_beat_t;

endpackage

// File: source/icache_req_buf.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_req_buf
    import icache_core_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       req_valid,
    input  fetch_req_t req,
    input  logic       cache_ready,
    output logic       req_take,
    output fetch_req_t cur,
    output index_t     lookup_index,
    output logic       is_op_clear_index,
    output logic       is_op_clear_hit
);

    logic op_index_kind;
    logic op_hit_kind;

    assign req_take = req_valid && cache_ready;

    // Other op codes target the data cache and fall through as fetches.
    assign op_index_kind = req.cacop_en && (req.op == op_store_tag || req.op == op_index_inv);
    assign op_hit_kind   = req.cacop_en && (req.op == op_hit_inv);

    // Arrays are read on the accept edge so tags are ready in LOOKUP.
    assign lookup_index = req_take ? req.addr[`ICACHE_OFS_W +: `ICACHE_IDX_W]
                                   : cur.addr[`ICACHE_OFS_W +: `ICACHE_IDX_W];

    always_ff @(posedge clk) begin
        if (req_take) begin
            cur <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            is_op_clear_index <= 1'b0;
            is_op_clear_hit   <= 1'b0;
        end else if (req_take) begin
            is_op_clear_index <= op_index_kind;
            is_op_clear_hit   <= op_hit_kind;
        end
    end

endmodule

// File: source/icache_main_fsm.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_main_fsm
    import icache_core_pkg::*;
    import icache_mem_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       req_valid,
    input  fetch_req_t cur,
    input  logic       is_op_clear_index,
    input  logic       is_op_clear_hit,
    input  way_mask_t  hit,
    input  way_mask_t  victim,
    input  logic       init_done,
    input  logic       mem_req_ready,
    input  logic       fill_done,
    output logic       cache_ready,
    input  logic       req_take,
    output way_mask_t  tag_we,
    output way_mask_t  data_we,
    output logic       valid_clear,
    output logic       rr_advance,
    output logic       mem_req_valid,
    output mem_req_t   mem_req,
    output logic       mem_beat_ready,
    output logic       data_valid,
    output logic       sel_line
);

    fsm_state_t state;
    fsm_state_t state_nxt;
    logic       any_hit;
    logic       done_in_lookup;
    way_mask_t  index_way;
    addr_t      line_addr;

    assign any_hit   = |hit;
    assign index_way = way_mask_t'(1'b1) << cur.addr[1:0];  // Way from low address bits.
    assign line_addr = {cur.addr[`ICACHE_ADDR_W-1:`ICACHE_OFS_W], {`ICACHE_OFS_W{1'b0}}};

    // Ops and cached hits finish in LOOKUP.
    assign done_in_lookup = is_op_clear_index || is_op_clear_hit
                            || (!cur.uncache && any_hit);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (req_take) state_nxt = st_lookup;
            end
            st_lookup: begin
                if (cur.exception) begin
                    state_nxt = st_idle;
                end else if (done_in_lookup) begin
                    state_nxt = req_valid ? st_lookup : st_idle;  // Ready is high here.
                end else begin
                    state_nxt = st_replace;
                end
            end
            st_replace: begin
                if (mem_req_ready) state_nxt = st_refill;
            end
            st_refill: begin
                if (fill_done) state_nxt = req_valid ? st_lookup : st_idle;
            end
            default: state_nxt = st_idle;
        endcase
    end

    // Request fields are held for the whole miss.
    always_comb begin
        mem_req.addr = cur.uncache ? cur.addr : line_addr;
        mem_req.len  = cur.uncache ? '0 : mem_len_t'(`ICACHE_LINE_WORDS - 1);
    end

    always_comb begin
        cache_ready    = 1'b0;
        tag_we         = '0;
        data_we        = '0;
        valid_clear    = 1'b0;
        rr_advance     = 1'b0;
        mem_req_valid  = 1'b0;
        mem_beat_ready = 1'b0;
        data_valid     = 1'b0;
        sel_line       = 1'b0;
        case (state)
            st_idle: begin
                cache_ready = init_done;  // Held off during the valid sweep.
            end
            st_lookup: begin
                if (cur.exception) begin
                    data_valid = 1'b0;
                end else if (is_op_clear_index) begin
                    valid_clear = 1'b1;
                    tag_we      = index_way;
                    data_valid  = 1'b1;
                    cache_ready = 1'b1;
                end else if (is_op_clear_hit) begin
                    valid_clear = 1'b1;
                    tag_we      = hit;
                    data_valid  = 1'b1;
                    cache_ready = 1'b1;
                end else if (!cur.uncache && any_hit) begin
                    data_valid  = 1'b1;
                    cache_ready = 1'b1;
                end
            end
            st_replace: begin
                mem_req_valid = 1'b1;
            end
            st_refill: begin
                mem_beat_ready = 1'b1;
                sel_line       = 1'b1;
                if (fill_done) begin
                    if (!cur.uncache) begin
                        tag_we     = victim;
                        data_we    = victim;
                        rr_advance = 1'b1;
                    end
                    data_valid  = 1'b1;
                    cache_ready = 1'b1;
                end
            end
            default: cache_ready = 1'b0;
        endcase
    end

endmodule

// File: source/icache_ways.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_ways
    import icache_core_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  index_t     lookup_index,
    input  fetch_req_t cur,
    input  way_mask_t  tag_we,
    input  way_mask_t  data_we,
    input  logic       valid_clear,
    input  logic       rr_advance,
    input  word_t      line [`ICACHE_LINE_WORDS],
    output way_mask_t  hit,
    output way_mask_t  victim,
    output word_t      hit_word,
    output logic       init_done
);

    localparam int WAY_W = $clog2(`ICACHE_WAYS);

    tag_t             tag_mem   [`ICACHE_WAYS][`ICACHE_SETS];
    logic             valid_mem [`ICACHE_WAYS][`ICACHE_SETS];
    word_t            data_mem  [`ICACHE_WAYS][`ICACHE_SETS][`ICACHE_LINE_WORDS];
    logic [WAY_W-1:0] rr_ptr    [`ICACHE_SETS];

    tag_t    rd_tag   [`ICACHE_WAYS];
    logic    rd_valid [`ICACHE_WAYS];
    word_t   rd_line  [`ICACHE_WAYS][`ICACHE_LINE_WORDS];
    logic    init_busy;
    index_t  init_cnt;
    index_t  wr_idx;
    tag_t    wr_tag;
    offset_t rd_ofs;

    assign wr_idx    = cur.addr[`ICACHE_OFS_W +: `ICACHE_IDX_W];
    assign wr_tag    = cur.addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign rd_ofs    = cur.addr[`ICACHE_OFS_W-1:0];
    assign init_done = !init_busy;
    assign victim    = way_mask_t'(1'b1) << rr_ptr[wr_idx];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            init_busy <= 1'b1;
            init_cnt  <= '0;
        end else if (init_busy) begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == index_t'(`ICACHE_SETS - 1)) init_busy <= 1'b0;
        end
    end

    // One set per cycle is cleared after reset.
    always_ff @(posedge clk) begin
        if (init_busy) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) valid_mem[w][init_cnt] <= 1'b0;
            rr_ptr[init_cnt] <= '0;
        end else begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (tag_we[w]) begin
                    tag_mem[w][wr_idx]   <= wr_tag;
                    valid_mem[w][wr_idx] <= !valid_clear;
                end
            end
            if (rr_advance) rr_ptr[wr_idx] <= rr_ptr[wr_idx] + 1'b1;
        end
    end

    // Registered read, new data forwarded on a same-set write.
    always_ff @(posedge clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (tag_we[w] && wr_idx == lookup_index) begin
                rd_tag[w]   <= wr_tag;
                rd_valid[w] <= !valid_clear;
            end else begin
                rd_tag[w]   <= tag_mem[w][lookup_index];
                rd_valid[w] <= valid_mem[w][lookup_index];
            end
            if (data_we[w] && wr_idx == lookup_index) begin
                rd_line[w] <= line;
            end else begin
                rd_line[w] <= data_mem[w][lookup_index];
            end
            if (data_we[w]) data_mem[w][wr_idx] <= line;
        end
    end

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit[w] = rd_valid[w] && (rd_tag[w] == wr_tag);
            if (hit[w]) hit_word = hit_word | rd_line[w][rd_ofs];
        end
    end

endmodule

// File: source/icache_refill_buf.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_refill_buf
    import icache_core_pkg::*;
    import icache_mem_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       mem_beat_valid,
    input  mem_beat_t  mem_beat,
    input  logic       mem_beat_ready,
    input  fetch_req_t cur,
    input  logic       sel_line,
    input  word_t      hit_word,
    output logic       fill_done,
    output word_t      line [`ICACHE_LINE_WORDS],
    output word_t      rdata
);

    logic    beat_take;
    offset_t beat_cnt;
    word_t   req_word;  // Word asked for by the current fetch.

    assign beat_take = mem_beat_valid && mem_beat_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_cnt  <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= beat_take && mem_beat.last;  // Result goes out the cycle after.
            if (beat_take) begin
                beat_cnt <= mem_beat.last ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    // Oldest beat ends up in word zero.
    always_ff @(posedge clk) begin
        if (beat_take) begin
            for (int i = 0; i < `ICACHE_LINE_WORDS - 1; i++) begin
                line[i] <= line[i+1];
            end
            line[`ICACHE_LINE_WORDS-1] <= mem_beat.data;
            if (cur.uncache || beat_cnt == cur.addr[`ICACHE_OFS_W-1:0]) begin
                req_word <= mem_beat.data;
            end
        end
    end

    assign rdata = sel_line ? req_word : hit_word;

endmodule

// File: source/icache_top.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_top
    import icache_core_pkg::*;
    import icache_mem_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       req_valid,
    input  fetch_req_t req,
    output logic       cache_ready,
    output logic       data_valid,
    output word_t      rdata,
    output logic       mem_req_valid,
    output mem_req_t   mem_req,
    input  logic       mem_req_ready,
    input  logic       mem_beat_valid,
    input  mem_beat_t  mem_beat,
    output logic       mem_beat_ready
);

    logic       req_take;
    fetch_req_t cur;
    index_t     lookup_index;
    logic       is_op_clear_index;
    logic       is_op_clear_hit;
    way_mask_t  hit;
    way_mask_t  victim;
    way_mask_t  tag_we;
    way_mask_t  data_we;
    logic       valid_clear;
    logic       rr_advance;
    logic       init_done;
    logic       fill_done;
    logic       sel_line;
    word_t      hit_word;
    word_t      line [`ICACHE_LINE_WORDS];

    icache_req_buf u_req_buf (.*);

    icache_main_fsm u_fsm (.*);

    icache_ways u_ways (.*);

    icache_refill_buf u_refill (.*);

endmodule

// File: test/icache_assertions.sv
`timescale 1ns/1ps

module icache_assertions
    import icache_mem_pkg::*;
(
    input logic     clk,
    input logic     rstn,
    input logic     req_valid,
    input logic     cache_ready,
    input logic     data_valid,
    input logic     mem_req_valid,
    input mem_req_t mem_req,
    input logic     mem_req_ready,
    input logic     mem_beat_ready
);

    int   fail_cnt = 0;
    logic open_req;  // Accepted and not yet answered.

    always_ff @(posedge clk) begin
        if (!rstn) begin
            open_req <= 1'b0;
        end else if (req_valid && cache_ready) begin
            open_req <= 1'b1;
        end else if (data_valid) begin
            open_req <= 1'b0;
        end
    end

    req_stable: assert property (@(posedge clk) disable iff (!rstn)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else begin
            $error("mem_req dropped or changed before mem_req_ready");
            fail_cnt++;
        end

    resp_after_accept: assert property (@(posedge clk) disable iff (!rstn)
        data_valid |-> open_req)
        else begin
            $error("data_valid without an accepted request");
            fail_cnt++;
        end

    no_beat_during_req: assert property (@(posedge clk) disable iff (!rstn)
        !(mem_beat_ready && mem_req_valid))
        else begin
            $error("mem_beat_ready high while mem_req_valid is high");
            fail_cnt++;
        end

endmodule

// File: test/icache_tb.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tb
    import icache_core_pkg::*;
    import icache_mem_pkg::*;
();

    localparam int          N_REQ     = 64;
    localparam int          WORST_CYC = 8 + 3 * `ICACHE_LINE_WORDS;  // Slowest miss in cycles.
    localparam int          T_LIMIT   = (N_REQ * WORST_CYC * 2 + 64) * 4;
    localparam logic [31:0] SEED      = 32'h3417_a1fe;

    typedef struct packed {
        logic     resp;
        logic     check_data;
        logic     mem;
        addr_t    mem_addr;
        mem_len_t len;
        word_t    data;
    } exp_t;

    logic       clk, rstn, req_valid, cache_ready, data_valid;
    logic       mem_req_valid, mem_req_ready, mem_beat_valid, mem_beat_ready;
    fetch_req_t req;
    word_t      rdata;
    mem_req_t   mem_req;
    mem_beat_t  mem_beat;

    tag_t sh_tag    [`ICACHE_WAYS][`ICACHE_SETS];
    logic sh_valid  [`ICACHE_WAYS][`ICACHE_SETS] = '{default: '{default: 1'b0}};
    int   sh_rr     [`ICACHE_SETS] = '{default: 0};
    exp_t exp_cur   = '0;
    int   mem_seen  = 0;
    int   resp_cnt  = 0;
    int   check_cnt = 0;
    int   err_cnt   = 0;

    icache_top u_dut (.*);

    bind icache_top icache_assertions u_check (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic word_t mem_word(input addr_t a);
        return ((a ^ 32'h5bd1_e995) * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
    endfunction

    // Shadow of tags, valid bits and round-robin pointers.
    function automatic exp_t ref_model(input fetch_req_t r);
        exp_t   e;
        index_t idx;
        tag_t   tg;
        int     hw;
        int     w;
        e   = '0;
        idx = r.addr[`ICACHE_OFS_W +: `ICACHE_IDX_W];
        tg  = r.addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        hw  = -1;
        for (int i = 0; i < `ICACHE_WAYS; i++) begin
            if (sh_valid[i][idx] && sh_tag[i][idx] == tg) hw = i;
        end
        if (r.exception) return e;
        e.resp = 1'b1;
        if (r.cacop_en && (r.op == op_store_tag || r.op == op_index_inv)) begin
            w = r.addr[1:0];  // Way named by the low address bits.
            sh_tag[w][idx]   = tg;
            sh_valid[w][idx] = 1'b0;
        end else if (r.cacop_en && r.op == op_hit_inv) begin
            if (hw >= 0) sh_valid[hw][idx] = 1'b0;
        end else begin
            e.check_data = 1'b1;
            e.data       = mem_word(r.addr);
            e.mem        = r.uncache || hw < 0;
            e.mem_addr   = r.uncache ? r.addr : {r.addr[31:`ICACHE_OFS_W], `ICACHE_OFS_W'(0)};
            e.len        = r.uncache ? '0 : mem_len_t'(`ICACHE_LINE_WORDS - 1);
            if (!r.uncache && hw < 0) begin
                w = sh_rr[idx];
                sh_tag[w][idx]   = tg;
                sh_valid[w][idx] = 1'b1;
                sh_rr[idx]       = (w + 1) % `ICACHE_WAYS;
            end
        end
        return e;
    endfunction

    task automatic send(input addr_t a, input logic unc, input logic exc, input logic cop,
                        input cacheop_t op);
        fetch_req_t r;
        int         target;
        r = '{addr: a, uncache: unc, exception: exc, cacop_en: cop, op: op};
        @(posedge clk);
        exp_cur   = ref_model(r);
        mem_seen  = 0;
        target    = resp_cnt + 1;
        req_valid <= 1'b1;
        req       <= r;
        do @(negedge clk); while (!cache_ready);
        @(posedge clk);
        req_valid <= 1'b0;
        if (exp_cur.resp) begin
            while (resp_cnt < target) @(posedge clk);
        end else begin
            do @(negedge clk); while (!cache_ready);  // Faulting request just drops back to idle.
        end
    endtask

    initial begin : memory_model
        logic [31:0] mrng;
        addr_t       base;
        mem_len_t    len;
        mem_beat_t   beat;
        mrng = SEED;
        wait (rstn === 1'b1);
        forever begin
            do @(negedge clk); while (mem_req_valid !== 1'b1);
            base = mem_req.addr;
            len  = mem_req.len;
            mrng = xorshift(mrng);
            repeat (mrng % 4) @(posedge clk);
            @(posedge clk);
            mem_req_ready <= 1'b1;
            @(posedge clk);
            mem_req_ready <= 1'b0;
            for (int i = 0; i <= int'(len); i++) begin
                mrng = xorshift(mrng);
                if (mrng % 3 != 0) begin
                    mem_beat_valid <= 1'b0;
                    repeat (mrng % 3) @(posedge clk);
                end
                beat.data = mem_word(base + addr_t'(i));
                beat.last = (i == int'(len));
                mem_beat_valid <= 1'b1;
                mem_beat       <= beat;
                do @(negedge clk); while (!mem_beat_ready);
                @(posedge clk);
            end
            mem_beat_valid <= 1'b0;
        end
    end

    initial begin : compare
        forever begin
            @(negedge clk);
            if (rstn && (mem_req_valid || mem_beat_ready) && !data_valid) begin
                check_cnt++;
                assert (!cache_ready) else begin
                    err_cnt++;
                    $display("error at %0t: cache_ready = %b, expected 0 while memory is busy",
                             $time, cache_ready);
                end
            end
            if (rstn && mem_req_valid && mem_req_ready) begin
                check_cnt++;
                mem_seen++;
                assert (exp_cur.mem) else begin
                    err_cnt++;
                    $display("memory request at %0t for a request that should hit or skip memory",
                             $time);
                end
                assert (mem_req.addr == exp_cur.mem_addr && mem_req.len == exp_cur.len) else begin
                    err_cnt++;
                    $display("error at %0t: mem_req = %h/%0d, expected %h/%0d", $time,
                             mem_req.addr, mem_req.len, exp_cur.mem_addr, exp_cur.len);
                end
            end
            if (rstn && data_valid) begin
                check_cnt++;
                resp_cnt++;
                assert (exp_cur.resp) else begin
                    err_cnt++;
                    $display("data_valid at %0t for a request that must end without data", $time);
                end
                assert (mem_seen == int'(exp_cur.mem)) else begin
                    err_cnt++;
                    $display("error at %0t: memory requests = %0d, expected %0d", $time,
                             mem_seen, exp_cur.mem);
                end
                if (exp_cur.check_data) begin
                    assert (rdata == exp_cur.data) else begin
                        err_cnt++;
                        $display("error at %0t: rdata = %h, expected %h", $time, rdata,
                                 exp_cur.data);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(T_LIMIT);
        $display("timeout after %0d ns, the run stalled with %0d errors", T_LIMIT, err_cnt);
        $display("** FAIL **");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] srng;
        addr_t       a;
        srng           = SEED;
        rstn           = 1'b0;
        req_valid      = 1'b0;
        req            = '0;
        mem_req_ready  = 1'b0;
        mem_beat_valid = 1'b0;
        mem_beat       = '0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        send(32'h0000_1230, 0, 0, 0, op_store_tag);  // Line fill, then hits.
        send(32'h0000_1231, 0, 0, 0, op_store_tag);
        send(32'h0000_1237, 0, 0, 0, op_store_tag);
        send(32'h0000_123f, 0, 0, 0, op_store_tag);
        send(32'h0000_2345, 1, 0, 0, op_store_tag);  // Uncached, then cached miss.
        send(32'h0000_2345, 0, 0, 0, op_store_tag);
        for (int i = 1; i <= 5; i++) begin
            send(addr_t'({i[23:0], 4'h5, i[3:0]}), 0, 0, 0, op_store_tag);
        end
        send(32'h0000_0252, 0, 0, 0, op_store_tag);
        send(32'h0000_0150, 0, 0, 0, op_store_tag);  // Evicted by the fifth line.
        send(32'h0000_1230, 0, 0, 1, op_index_inv);
        send(32'h0000_1234, 0, 0, 0, op_store_tag);
        send(32'h0000_1235, 0, 0, 1, op_hit_inv);
        send(32'h0000_1236, 0, 0, 0, op_store_tag);
        send(32'h0000_2343, 0, 0, 1, op_store_tag);
        send(32'h0000_2340, 0, 0, 0, op_store_tag);
        send(32'h0000_7770, 0, 0, 1, op_hit_inv);
        send(32'h0000_3000, 0, 1, 0, op_store_tag);  // Translation fault.
        send(32'h0000_3000, 0, 0, 0, op_store_tag);
        repeat (36) begin
            srng = xorshift(srng);
            a    = {21'h0, srng[10:8], 2'b00, srng[5:0]};
            send(a, srng[20:18] == 3'd0, 1'b0, srng[23:21] == 3'd0, op_hit_inv);
        end
        repeat (4) @(posedge clk);
        err_cnt = err_cnt + u_dut.u_check.fail_cnt;
        $display("checks: %0d, responses: %0d, errors: %0d", check_cnt, resp_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+source
source/icache_core_pkg.sv
source/icache_mem_pkg.sv
source/icache_req_buf.sv
source/icache_main_fsm.sv
source/icache_ways.sv
source/icache_refill_buf.sv
source/icache_top.sv
test/icache_assertions.sv
test/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - source
    files:
      - source/icache_core_pkg.sv
      - source/icache_mem_pkg.sv
      - source/icache_req_buf.sv
      - source/icache_main_fsm.sv
      - source/icache_ways.sv
      - source/icache_refill_buf.sv
      - source/icache_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/icache_assertions.sv
      - test/icache_tb.sv
